// File: Bender.yml
package:
  name: tree_machine

sources:
  - include_dirs:
      - logic
    files:
      - logic/isaPkg.sv
      - logic/corePkg.sv
      - logic/codeStore.sv
      - logic/operandDecode.sv
      - logic/executeUnit.sv
      - logic/resultWriter.sv
      - logic/treeMachine.sv
      - target: test
        files:
          - bench/treeMachineTb.sv

// File: bench/treeMachineTb.sv
/*
  Testbench for the operand machine. Loads programs through the load port,
  predicts the output sequence with a small reference model and acknowledges
  outputs after random delays. Assertions check handshakes, values and finish.
*/
`default_nettype none

`include "machine_defines.svh"

module treeMachineTb;
  timeunit 1ns;
  timeprecision 1ps;

  import corePkg::*;
  import isaPkg::*;

  logic        clock;
  logic        arstN;
  logic        run;
  logic        loadReq;
  codeAddrT    loadAddr;
  instructionT loadWord;
  logic        loadAck;
  logic        outReq;
  wordT        outData;
  logic        outAck;
  logic        finished;

  instructionT prog [$];                              // program under test
  wordT        expectQ [$];                           // outputs still to come
  wordT        modelMem [0:`LOCAL_DEPTH-1];
  logic [15:0] lfsr = 16'd55990;
  int          cycles = 0;
  int          cycleLimit = 200;                      // grows with each load and run

  treeMachine DUT (.*);

  always #10 clock = ~clock;

  task automatic stopRun(input string line);
    $display("%s", line);
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  // ------------------------------
  // random ack delays
  // ------------------------------
  function automatic logic nextBit();
    logic feedback;
    feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];   // x^16+x^14+x^13+x^11+1
    lfsr = {lfsr[14:0], feedback};
    return feedback;
  endfunction

  function automatic int ackDelay();
    int delay;
    delay = 0;
    repeat (3) delay = (delay << 1) | nextBit();      // 0 to 7 cycles
    return delay;
  endfunction

  // ------------------------------
  // program encoding
  // ------------------------------
  function automatic operandT immediate(input int value);
    return '{modeImmediate, 8'd0, 16'(value)};
  endfunction

  function automatic operandT direct(input int delta, input int addr);
    return '{modeDirect, 8'(delta), 16'(addr)};
  endfunction

  function automatic operandT indirect(input int delta, input int addr);
    return '{modeIndirect, 8'(delta), 16'(addr)};
  endfunction

  function automatic instructionT encode(input opcodeT op, input operandT target,
                                         input operandT src1, input operandT src2);
    return '{op, target, src1, src2};
  endfunction

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic int cellOf(input operandT op);
    int base;
    base = int'(op.address);
    if (op.mode == modeIndirect) base = int'(modelMem[base % `LOCAL_DEPTH]);
    return (int'(op.delta) + base) & (`LOCAL_DEPTH - 1);
  endfunction

  function automatic wordT readOperand(input operandT op);
    if (op.mode == modeImmediate) return wordT'(op.address);
    return modelMem[cellOf(op)];
  endfunction

  task automatic predictOutputs();
    instructionT word;
    wordT        a;
    wordT        b;
    wordT        value;
    logic        taken;
    int          pc;
    int          steps;
    pc    = 0;
    steps = 0;
    while (pc >= 0 && pc < prog.size() && steps < 1000) begin
      word  = prog[pc];
      a     = readOperand(word.source1);
      b     = readOperand(word.source2);
      value = '0;
      taken = 1'b0;
      case (word.opcode)
        opAdd:      value = a + b;
        opSubtract: value = a - b;
        opMov:      value = a;
        opNot:      value = (a == 0) ? wordT'(1) : wordT'(0);
        opOut:      expectQ.push_back(a);
        opJmp:      taken = 1'b1;
        opJEq:      taken = (a == b);
        opJNe:      taken = (a != b);
        opJLt:      taken = (a < b);
        opJGe:      taken = (a >= b);
        opJTrue:    taken = (a != 0);
        opJFalse:   taken = (a == 0);
        default:    ;
      endcase
      if (word.opcode inside {opAdd, opSubtract, opMov, opNot} &&
          word.target.mode != modeImmediate) begin
        modelMem[cellOf(word.target)] = value;
      end
      pc = taken ? pc + int'($signed(word.target.address)) : pc + 1;
      steps++;
    end
  endtask

  // ------------------------------
  // programs
  // ------------------------------
  task automatic arithProgram();
    prog.delete();
    prog.push_back(encode(opMov, direct(2, 1), immediate(100), immediate(0)));
    prog.push_back(encode(opAdd, direct(0, 4), immediate(7), immediate(-3)));
    prog.push_back(encode(opSubtract, direct(1, 4), direct(0, 3), immediate(25)));
    prog.push_back(encode(opNot, direct(0, 6), immediate(0), immediate(0)));
    prog.push_back(encode(opNot, direct(0, 7), direct(0, 5), immediate(0)));
    prog.push_back(encode(opMov, direct(0, 8), immediate(5), immediate(0)));
    prog.push_back(encode(opMov, indirect(4, 8), immediate(-42), immediate(0)));
    prog.push_back(encode(opOut, immediate(0), direct(0, 3), immediate(0)));
    prog.push_back(encode(opOut, immediate(0), indirect(0, 8), immediate(0)));
    prog.push_back(encode(opOut, immediate(0), indirect(1, 8), immediate(0)));
    prog.push_back(encode(opOut, immediate(0), direct(0, 7), immediate(0)));
    prog.push_back(encode(opOut, immediate(0), indirect(4, 8), immediate(0)));
    prog.push_back(encode(opAdd, direct(0, 10), direct(0, 10), indirect(0, 8)));  // accumulates
    prog.push_back(encode(opOut, immediate(0), direct(0, 10), immediate(0)));
  endtask

  // each branch pair is taken then not taken, a skipped out shows up as a bad value
  task automatic branchProgram();
    opcodeT ops [6];
    int     yes [6][2];
    int     no [6][2];
    ops = '{opJEq, opJNe, opJLt, opJGe, opJTrue, opJFalse};
    yes = '{'{5, 5}, '{1, 2}, '{-1, 1}, '{3, 3}, '{9, 0}, '{0, 0}};
    no  = '{'{5, 6}, '{4, 4}, '{3, 3}, '{-2, 0}, '{0, 0}, '{1, 0}};
    prog.delete();
    prog.push_back(encode(opMov, direct(0, 0), immediate(3), immediate(0)));
    prog.push_back(encode(opOut, immediate(0), direct(0, 0), immediate(0)));  // loop top
    prog.push_back(encode(opSubtract, direct(0, 0), direct(0, 0), immediate(1)));
    prog.push_back(encode(opJFalse, immediate(2), direct(0, 0), immediate(0)));
    prog.push_back(encode(opJmp, immediate(-3), immediate(0), immediate(0)));  // backward
    foreach (ops[i]) begin
      prog.push_back(encode(ops[i], immediate(2), immediate(yes[i][0]), immediate(yes[i][1])));
      prog.push_back(encode(opOut, immediate(0), immediate(1000 + i), immediate(0)));
      prog.push_back(encode(ops[i], immediate(2), immediate(no[i][0]), immediate(no[i][1])));
      prog.push_back(encode(opOut, immediate(0), immediate(10 + i), immediate(0)));
    end
    prog.push_back(encode(opJmp, immediate(2), immediate(0), immediate(0)));   // to the end
    prog.push_back(encode(opOut, immediate(0), immediate(2000), immediate(0)));
  endtask

  // ------------------------------
  // load and run
  // ------------------------------
  task automatic loadProgram();
    cycleLimit += prog.size() * 10;
    for (int i = 0; i < prog.size(); i++) begin
      loadReq  <= 1'b1;
      loadAddr <= codeAddrT'(i);
      loadWord <= prog[i];
      do @(posedge clock); while (!loadAck);
      loadReq <= 1'b0;
      do @(posedge clock); while (loadAck);
    end
  endtask

  task automatic runProgram();
    cycleLimit += prog.size() * 10;
    predictOutputs();
    run <= 1'b1;
    do @(posedge clock); while (!finished);
    assert (expectQ.size() == 0 && !outReq)
      else stopRun($sformatf("FAIL %0t: finished with %0d outputs missing", $time,
                             expectQ.size()));
    repeat (4) @(posedge clock);                      // finished must hold meanwhile
    run <= 1'b0;
    do @(posedge clock); while (finished);
  endtask

  // output side of the host, checks each value as it is offered
  always begin
    @(posedge clock);
    if (outReq && !outAck) begin
      assert (expectQ.size() > 0)
        else stopRun($sformatf("FAIL %0t: unexpected output %0d", $time, outData));
      assert (outData == expectQ[0])
        else stopRun($sformatf("FAIL %0t: output %0d, expected %0d", $time, outData,
                               expectQ[0]));
      void'(expectQ.pop_front());
      repeat (ackDelay()) @(posedge clock);
      outAck <= 1'b1;
      do @(posedge clock); while (outReq);
      repeat (ackDelay()) @(posedge clock);
      outAck <= 1'b0;
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > cycleLimit) stopRun($sformatf("timeout: no result after %0d cycles", cycles));
  end

  // ------------------------------
  // handshake and finish checks
  // ------------------------------
  assert property (@(posedge clock) disable iff (!arstN) $rose(loadAck) |-> $past(loadReq))
    else stopRun($sformatf("FAIL %0t: loadAck rose without loadReq", $time));
  assert property (@(posedge clock) disable iff (!arstN) $fell(loadAck) |-> !$past(loadReq))
    else stopRun($sformatf("FAIL %0t: loadAck fell while loadReq high", $time));
  assert property (@(posedge clock) disable iff (!arstN)
                   outReq && !outAck |=> outReq && $stable(outData))
    else stopRun($sformatf("FAIL %0t: outReq or outData changed before outAck", $time));
  assert property (@(posedge clock) disable iff (!arstN) $rose(outReq) |-> !$past(outAck))
    else stopRun($sformatf("FAIL %0t: outReq rose while outAck high", $time));
  assert property (@(posedge clock) disable iff (!arstN) finished && run |=> finished)
    else stopRun($sformatf("FAIL %0t: finished dropped while run high", $time));
  assert property (@(posedge clock) disable iff (!arstN) !run |=> !finished)
    else stopRun($sformatf("FAIL %0t: finished high while run low", $time));

  initial begin
    clock    = 1'b0;
    arstN    = 1'b0;
    run      = 1'b0;
    loadReq  = 1'b0;
    loadAddr = '0;
    loadWord = '0;
    outAck   = 1'b0;
    foreach (modelMem[i]) modelMem[i] = '0;
    repeat (16) @(posedge clock);
    arstN <= 1'b1;
    repeat (2) @(posedge clock);
    assert (!finished && !outReq && !loadAck)
      else stopRun($sformatf("FAIL %0t: outputs not idle after reset", $time));
    arithProgram();
    loadProgram();
    runProgram();
    runProgram();                                     // replay, memory kept from first run
    branchProgram();
    loadProgram();
    runProgram();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+logic
logic/isaPkg.sv
logic/corePkg.sv
logic/codeStore.sv
logic/operandDecode.sv
logic/executeUnit.sv
logic/resultWriter.sv
logic/treeMachine.sv
bench/treeMachineTb.sv

// File: logic/codeStore.sv
/*
  Code memory behind a four-phase load port. Loads are taken only while
  run is low; the first load after a run starts a new program length.
*/
`default_nettype none

`include "machine_defines.svh"

module codeStore (
  input  logic                clock,
  input  logic                arstN,
  input  logic                run,
  input  logic                loadReq,
  input  corePkg::codeAddrT   loadAddr,
  input  isaPkg::instructionT loadWord,
  output logic                loadAck,
  input  corePkg::codeAddrT   ip,
  output isaPkg::instructionT instruction,
  output corePkg::codeAddrT   programLength
);
  import corePkg::*;
  import isaPkg::*;

  instructionT code [0:`CODE_DEPTH-1];
  logic        newProgram;                              // next load restarts the length
  codeAddrT    loadEnd;
  logic        loadStrobe;

  assign loadEnd    = codeAddrT'(loadAddr + 1'b1);
  assign loadStrobe = !run && loadReq && !loadAck;      // phase 1 seen, ack not yet up

  always_ff @(posedge clock) begin
    if (loadStrobe && loadAddr < `CODE_DEPTH) begin
      code[loadAddr[$clog2(`CODE_DEPTH)-1:0]] <= loadWord;
    end
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      loadAck       <= 1'b0;
      programLength <= '0;
      newProgram    <= 1'b1;
    end else begin
      if (loadStrobe) begin
        loadAck    <= 1'b1;
        newProgram <= 1'b0;
        if (newProgram || loadEnd > programLength) begin
          programLength <= loadEnd;                     // highest address plus one
        end
      end else if (!loadReq && loadAck) begin
        loadAck <= 1'b0;                                // phase 4
      end
      if (run) begin
        newProgram <= 1'b1;
      end
    end
  end

  assign instruction = code[ip[$clog2(`CODE_DEPTH)-1:0]];   // out-of-range ip is never executed

endmodule

`default_nettype wire

// File: logic/corePkg.sv
/*
  Machine state and data types: words, local and code addresses,
  and the run states of the execute FSM.
*/
`default_nettype none

`include "machine_defines.svh"

package corePkg;

  typedef logic signed [`WORD_WIDTH-1:0] wordT;

  typedef logic [$clog2(`LOCAL_DEPTH)-1:0] localAddrT;

  // one extra bit so the pointer can sit at the end of a full program
  typedef logic [$clog2(`CODE_DEPTH):0] codeAddrT;

  typedef enum logic [1:0] {
    stateIdle    = 2'd0,
    stateRunning = 2'd1,
    stateOutWait = 2'd2,
    stateDone    = 2'd3
  } runStateT;

endpackage

`default_nettype wire

// File: logic/executeUnit.sv
/*
  Run FSM and instruction pointer. Computes arithmetic results and branch
  decisions; an out instruction waits in outWait for the output handshake.
*/
`default_nettype none

`include "machine_defines.svh"

module executeUnit (
  input  logic                clock,
  input  logic                arstN,
  input  logic                run,
  input  isaPkg::instructionT instruction,
  input  corePkg::codeAddrT   programLength,
  input  corePkg::wordT       source1Value,
  input  corePkg::wordT       source2Value,
  input  corePkg::wordT       jumpOffset,
  input  logic                outDone,
  output corePkg::codeAddrT   ip,
  output corePkg::wordT       result,
  output logic                writeEnable,
  output logic                outStart,
  output logic                finished
);
  import corePkg::*;
  import isaPkg::*;

  runStateT state;
  logic     inRange;
  logic     isArith;
  logic     taken;
  wordT     jumpTarget;
  codeAddrT nextIp;

  assign inRange = ip < programLength;

  // ------------------------------
  // opcode decode
  // ------------------------------
  always_comb begin
    result  = '0;
    isArith = 1'b0;
    taken   = 1'b0;
    case (instruction.opcode)
      opAdd:      begin result = source1Value + source2Value; isArith = 1'b1; end
      opSubtract: begin result = source1Value - source2Value; isArith = 1'b1; end
      opMov:      begin result = source1Value;                isArith = 1'b1; end
      opNot:      begin result = (source1Value == 0) ? wordT'(1) : '0; isArith = 1'b1; end
      opJmp:      taken = 1'b1;
      opJEq:      taken = source1Value == source2Value;
      opJNe:      taken = source1Value != source2Value;
      opJLt:      taken = source1Value <  source2Value;  // signed compare
      opJGe:      taken = source1Value >= source2Value;
      opJTrue:    taken = source1Value != 0;
      opJFalse:   taken = source1Value == 0;
      default:    ;                                       // out and unknown codes
    endcase
  end

  // a jump outside the code memory parks the pointer at the end
  assign jumpTarget = wordT'(ip) + jumpOffset;

  always_comb begin
    if (!taken) begin
      nextIp = codeAddrT'(ip + 1'b1);
    end else if (jumpTarget < 0 || jumpTarget > `CODE_DEPTH) begin
      nextIp = codeAddrT'(`CODE_DEPTH);
    end else begin
      nextIp = codeAddrT'(jumpTarget);
    end
  end

  assign writeEnable = isArith && inRange && state == stateRunning;
  assign outStart    = instruction.opcode == opOut && inRange && state == stateRunning;
  assign finished    = state == stateDone;

  // ------------------------------
  // run FSM
  // ------------------------------
  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      state <= stateIdle;
      ip    <= '0;
    end else if (!run) begin
      state <= stateIdle;                                 // ready to replay
      ip    <= '0;
    end else begin
      case (state)
        stateIdle: state <= stateRunning;
        stateRunning: begin
          if (!inRange) begin
            state <= stateDone;
          end else if (instruction.opcode == opOut) begin
            state <= stateOutWait;
          end else begin
            ip <= nextIp;
          end
        end
        stateOutWait: begin
          if (outDone) begin
            ip    <= codeAddrT'(ip + 1'b1);
            state <= stateRunning;
          end
        end
        default: ;                                        // done holds until run falls
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/isaPkg.sv
/*
  Instruction format of the operand machine: opcodes, addressing modes
  and the packed operand and instruction words loaded by the host.
*/
`default_nettype none

`include "machine_defines.svh"

package isaPkg;

  // numbering follows the full instruction set, only a subset is kept
  typedef enum logic [`OPCODE_WIDTH-1:0] {
    opAdd      = 0,
    opJEq      = 22,
    opJFalse   = 23,
    opJGe      = 24,
    opJLt      = 27,
    opJNe      = 28,
    opJTrue    = 29,
    opJmp      = 30,
    opMov      = 34,
    opNot      = 37,
    opOut      = 38,
    opSubtract = 56
  } opcodeT;

  typedef enum logic [1:0] {
    modeImmediate = 2'd0,       // the address field is the value
    modeDirect    = 2'd1,       // local memory at delta + address
    modeIndirect  = 2'd2        // local memory at delta + mem[address]
  } modeT;

  typedef struct packed {
    modeT                    mode;
    logic [`DELTA_WIDTH-1:0] delta;
    logic [`WORD_WIDTH-1:0]  address;   // also the jump offset in a target
  } operandT;

  typedef struct packed {
    opcodeT  opcode;
    operandT target;
    operandT source1;
    operandT source2;
  } instructionT;

endpackage

`default_nettype wire

// File: logic/machine_defines.svh
/*
  Widths and depths of the operand machine.
  Include this wherever a size is needed; the guard makes repeats harmless.
*/
`ifndef MACHINE_DEFINES_SVH
`define MACHINE_DEFINES_SVH

// ------------------------------
// data path
// ------------------------------
`define WORD_WIDTH 16           // data word and operand address field
`define DELTA_WIDTH 8           // operand delta field

// ------------------------------
// memories
// ------------------------------
`define LOCAL_DEPTH 16          // local memory words
`define CODE_DEPTH 32           // instruction slots

// ------------------------------
// instruction encoding
// ------------------------------
`define OPCODE_WIDTH 6          // opcode field

`endif

// File: logic/operandDecode.sv
/*
  Resolves the operands of the current instruction against local memory.
  Sources become values, the target becomes a local memory location.
*/
`default_nettype none

`include "machine_defines.svh"

module operandDecode (
  input  isaPkg::instructionT instruction,
  input  corePkg::wordT       localMem [0:`LOCAL_DEPTH-1],
  output corePkg::wordT       source1Value,
  output corePkg::wordT       source2Value,
  output corePkg::localAddrT  targetAddr,
  output logic                targetValid,
  output corePkg::wordT       jumpOffset
);
  import corePkg::*;
  import isaPkg::*;

  // ------------------------------
  // address resolution
  // ------------------------------
  function automatic localAddrT locate(input operandT op,
                                       input wordT mem [0:`LOCAL_DEPTH-1]);
    localAddrT pointer;
    pointer = localAddrT'(op.address);
    case (op.mode)
      modeIndirect: locate = localAddrT'(op.delta + mem[pointer]);
      default:      locate = localAddrT'(op.delta + op.address);
    endcase
  endfunction

  function automatic wordT valueOf(input operandT op,
                                   input wordT mem [0:`LOCAL_DEPTH-1]);
    case (op.mode)
      modeImmediate: valueOf = wordT'(op.address);
      modeDirect,
      modeIndirect:  valueOf = mem[locate(op, mem)];
      default:       valueOf = '0;                      // unused mode reads as zero
    endcase
  endfunction

  // ------------------------------
  // operands
  // ------------------------------
  assign source1Value = valueOf(instruction.source1, localMem);
  assign source2Value = valueOf(instruction.source2, localMem);

  assign targetAddr  = locate(instruction.target, localMem);
  assign targetValid = (instruction.target.mode == modeDirect) ||
                       (instruction.target.mode == modeIndirect);

  // jumps carry their relative distance in the target address field
  assign jumpOffset = wordT'(instruction.target.address);

endmodule

`default_nettype wire

// File: logic/resultWriter.sv
/*
  Local memory writeback and the four-phase output channel.
  outDone pulses for one cycle once the host has dropped outAck.
*/
`default_nettype none

`include "machine_defines.svh"

module resultWriter (
  input  logic               clock,
  input  logic               arstN,
  input  logic               writeEnable,
  input  corePkg::localAddrT targetAddr,
  input  logic               targetValid,
  input  corePkg::wordT      result,
  input  logic               outStart,
  input  corePkg::wordT      outValue,
  output corePkg::wordT      localMem [0:`LOCAL_DEPTH-1],
  output logic               outReq,
  output corePkg::wordT      outData,
  input  logic               outAck,
  output logic               outDone
);
  import corePkg::*;

  logic ackLowWait;                                     // start seen while ack still high
  logic ackSeen;                                        // phase 2 seen, waiting for phase 4

  // ------------------------------
  // local memory
  // ------------------------------
  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `LOCAL_DEPTH; i++) begin
        localMem[i] <= '0;
      end
    end else if (writeEnable && targetValid) begin
      localMem[targetAddr] <= result;
    end
  end

  // ------------------------------
  // output channel
  // ------------------------------
  always_ff @(posedge clock) begin
    if (outStart) begin
      outData <= outValue;                              // held until the next out
    end
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      outReq     <= 1'b0;
      ackLowWait <= 1'b0;
      ackSeen    <= 1'b0;
    end else if (outStart) begin
      if (outAck) begin
        ackLowWait <= 1'b1;
      end else begin
        outReq <= 1'b1;
      end
    end else if (ackLowWait && !outAck) begin
      ackLowWait <= 1'b0;
      outReq     <= 1'b1;
    end else if (outReq && outAck) begin
      outReq  <= 1'b0;                                  // phase 3
      ackSeen <= 1'b1;
    end else if (outDone) begin
      ackSeen <= 1'b0;
    end
  end

  assign outDone = ackSeen && !outAck;

endmodule

`default_nettype wire

// File: logic/treeMachine.sv
/*
  Top level of the operand machine. Load a program through the load port
  with run low, then raise run; results leave through the output channel.
*/
`default_nettype none

`include "machine_defines.svh"

module treeMachine (
  input  logic                clock,
  input  logic                arstN,
  input  logic                run,
  input  logic                loadReq,
  input  corePkg::codeAddrT   loadAddr,
  input  isaPkg::instructionT loadWord,
  output logic                loadAck,
  output logic                outReq,
  output corePkg::wordT       outData,
  input  logic                outAck,
  output logic                finished
);
  import corePkg::*;
  import isaPkg::*;

  instructionT instruction;
  codeAddrT    ip;
  codeAddrT    programLength;
  wordT        source1Value;
  wordT        source2Value;
  wordT        jumpOffset;
  wordT        result;
  localAddrT   targetAddr;
  logic        targetValid;
  logic        writeEnable;
  logic        outStart;
  logic        outDone;
  wordT        localMem [0:`LOCAL_DEPTH-1];

  codeStore codeStoreInst (
    .clock, .arstN, .run,
    .loadReq, .loadAddr, .loadWord, .loadAck,
    .ip, .instruction, .programLength
  );

  operandDecode operandDecodeInst (
    .instruction, .localMem,
    .source1Value, .source2Value,
    .targetAddr, .targetValid, .jumpOffset
  );

  executeUnit executeUnitInst (
    .clock, .arstN, .run,
    .instruction, .programLength,
    .source1Value, .source2Value, .jumpOffset,
    .outDone, .ip, .result, .writeEnable, .outStart, .finished
  );

  resultWriter resultWriterInst (
    .clock, .arstN,
    .writeEnable, .targetAddr, .targetValid, .result,
    .outStart, .outValue (source1Value),                // out sends its first source
    .localMem, .outReq, .outData, .outAck, .outDone
  );

endmodule

`default_nettype wire
